/* logic/gpio_pkg.sv */
`default_nettype none

package gpio_pkg;

    localparam int NPINS  = 8;                  // pins in the block
    localparam int PIN_W  = $clog2(NPINS);      // pin index width
    localparam int APB_AW = 8;                  // apb address width
    localparam int APB_DW = 32;                 // apb data width
    localparam int CFG_W  = 16;                 // pad config word width

    // register map, byte offsets
    localparam logic [APB_AW-1:0] REG_DOUT     = 8'h00;  // output value
    localparam logic [APB_AW-1:0] REG_OE       = 8'h04;  // output enable
    localparam logic [APB_AW-1:0] REG_IE       = 8'h08;  // input enable
    localparam logic [APB_AW-1:0] REG_PE       = 8'h0C;  // pull enable
    localparam logic [APB_AW-1:0] REG_PS       = 8'h10;  // pull select, 1 = up
    localparam logic [APB_AW-1:0] REG_DIN      = 8'h14;  // synced input, read only
    localparam logic [APB_AW-1:0] REG_IRQ_STAT = 8'h18;  // rising edge status, w1c
    localparam logic [APB_AW-1:0] REG_IRQ_MASK = 8'h1C;  // irq enable per pin
    localparam logic [APB_AW-1:0] REG_CFG0     = 8'h20;  // pin 0 config word
    // first offset past the config words
    localparam logic [APB_AW-1:0] REG_CFG_END  = REG_CFG0 + APB_AW'(4 * NPINS);

    // pad config word, bit 0 is hold_n
    typedef struct packed {
        logic [2:0] dm;          // drive mode, stored only
        logic       analog_pol;  // stored only
        logic       analog_sel;  // stored only
        logic       analog_en;   // stored only
        logic       hold_ovr;    // stored only
        logic [5:0] rsvd;        // supply / trip bits, stored only
        logic       enable_inp;  // stored only
        logic       enable;      // 0 = cell never drives
        logic       hold_n;      // 0 = freeze out and oe
    } pad_cfg_t;

    localparam pad_cfg_t CFG_RESET = 16'h0003;  // hold_n and enable set

    // drive from the board side of one pad
    typedef struct packed {
        logic en;   // external side drives
        logic val;  // driven value
    } pad_ext_t;

    // what the pad shows after resolution
    typedef struct packed {
        logic level;  // resolved pad level
        logic clash;  // core and external fight
    } pad_obs_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;   // tied high, no wait states
        logic              pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

/* logic/gpio_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_apb_regs (
    input  logic                                     clk,
    input  logic                                     rst,
    input  gpio_pkg::apb_req_t                       apb_req,
    output gpio_pkg::apb_rsp_t                       apb_rsp,
    input  logic [gpio_pkg::NPINS-1:0]               din,   // synchronized pad level
    input  logic [gpio_pkg::NPINS-1:0]               rise,  // one cycle edge pulse
    output logic [gpio_pkg::NPINS-1:0]               dout,
    output logic [gpio_pkg::NPINS-1:0]               oe,
    output logic [gpio_pkg::NPINS-1:0]               ie,
    output logic [gpio_pkg::NPINS-1:0]               pe,
    output logic [gpio_pkg::NPINS-1:0]               ps,
    output gpio_pkg::pad_cfg_t [gpio_pkg::NPINS-1:0] cfg,
    output logic                                     irq
);
    import gpio_pkg::*;

    logic              access;     // access phase, pready always high
    logic              aligned;
    logic              cfg_hit;    // offset inside config window
    logic [PIN_W-1:0]  cfg_idx;
    logic              map_hit;    // any mapped offset
    logic              err;
    logic              wr;         // write that commits on this edge
    logic [NPINS-1:0]  wdata;
    logic [NPINS-1:0]  stat;       // sticky rising edge status
    logic [NPINS-1:0]  mask;
    logic [NPINS-1:0]  stat_clr;
    logic [APB_DW-1:0] rd_data;

    assign access  = apb_req.psel & apb_req.penable;
    assign aligned = (apb_req.paddr[1:0] == 2'b00);
    assign cfg_hit = aligned && (apb_req.paddr >= REG_CFG0) && (apb_req.paddr < REG_CFG_END);
    assign cfg_idx = PIN_W'((apb_req.paddr - REG_CFG0) >> 2);
    assign map_hit = cfg_hit || (aligned && (apb_req.paddr <= REG_IRQ_MASK));
    assign err     = access & (~map_hit | (apb_req.pwrite & (apb_req.paddr == REG_DIN)));
    assign wr      = access & apb_req.pwrite & ~err;  // erroring write is dropped
    assign wdata   = apb_req.pwdata[NPINS-1:0];

    assign stat_clr = (wr && apb_req.paddr == REG_IRQ_STAT) ? wdata : '0;

    // control registers
    always_ff @(posedge clk) begin
        if (rst) begin
            dout <= '0;
            oe   <= '0;  // all pads hi-z out of reset
            ie   <= '1;
            pe   <= '0;
            ps   <= '0;
            mask <= '0;
        end else if (wr && !cfg_hit) begin
            case (apb_req.paddr)
                REG_DOUT:     dout <= wdata;
                REG_OE:       oe   <= wdata;
                REG_IE:       ie   <= wdata;
                REG_PE:       pe   <= wdata;
                REG_PS:       ps   <= wdata;
                REG_IRQ_MASK: mask <= wdata;
                default:      ;  // din and stat handled elsewhere
            endcase
        end
    end

    // per pin config words
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NPINS; i++) begin
                cfg[i] <= CFG_RESET;
            end
        end else if (wr && cfg_hit) begin
            cfg[cfg_idx] <= pad_cfg_t'(apb_req.pwdata[CFG_W-1:0]);
        end
    end

    // status: set wins over clear
    always_ff @(posedge clk) begin
        if (rst) begin
            stat <= '0;
            irq  <= 1'b0;
        end else begin
            stat <= (stat & ~stat_clr) | rise;
            irq  <= |(stat & mask);  // one cycle behind status
        end
    end

    // read mux
    always_comb begin
        rd_data = '0;
        if (cfg_hit) begin
            rd_data = {{(APB_DW-CFG_W){1'b0}}, cfg[cfg_idx]};
        end else begin
            case (apb_req.paddr)
                REG_DOUT:     rd_data = APB_DW'(dout);
                REG_OE:       rd_data = APB_DW'(oe);
                REG_IE:       rd_data = APB_DW'(ie);
                REG_PE:       rd_data = APB_DW'(pe);
                REG_PS:       rd_data = APB_DW'(ps);
                REG_DIN:      rd_data = APB_DW'(din);
                REG_IRQ_STAT: rd_data = APB_DW'(stat);
                REG_IRQ_MASK: rd_data = APB_DW'(mask);
                default:      rd_data = '0;
            endcase
        end
    end

    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = err;

endmodule

`default_nettype wire

/* logic/gpio_in_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_in_sync (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [gpio_pkg::NPINS-1:0] z,     // async pad levels, ie applied
    output logic [gpio_pkg::NPINS-1:0] din,   // synchronized level
    output logic [gpio_pkg::NPINS-1:0] rise   // 0 -> 1 pulse, one cycle
);

    logic [gpio_pkg::NPINS-1:0] meta;   // first stage, may go metastable
    logic [gpio_pkg::NPINS-1:0] sync;   // second stage, safe to use
    logic [gpio_pkg::NPINS-1:0] prev;   // last cycle's sync value

    always_ff @(posedge clk) begin
        if (rst) begin
            meta <= '0;
            sync <= '0;
            prev <= '0;
        end else begin
            meta <= z;
            sync <= meta;
            prev <= sync;  // edge reference
        end
    end

    assign din  = sync;
    assign rise = sync & ~prev;  // high only on the first cycle at one

endmodule

`default_nettype wire

/* logic/la_iobidir.sv */
`timescale 1ns/1ps
`default_nettype none

module la_iobidir (
    input  logic               clk,
    input  logic               rst,
    // core side
    input  logic               a,     // value to drive out
    output logic               z,     // level back to core
    input  logic               ie,    // input enable, 1 = active
    input  logic               oe,    // output enable, 1 = active
    input  logic               pe,    // pull enable
    input  logic               ps,    // pull select, 1 = up, 0 = down
    input  gpio_pkg::pad_cfg_t cfg,   // pad config word
    // board side
    input  gpio_pkg::pad_ext_t ext,   // external driver
    output gpio_pkg::pad_obs_t pad    // resolved level and clash
);

    logic a_hold;   // frozen copy of a
    logic oe_hold;  // frozen copy of oe
    logic keep;     // bus keeper, last resolved level
    logic a_eff;
    logic oe_eff;
    logic drive;    // core actually drives the pad
    logic level;

    // copies track the live inputs until hold_n drops
    always_ff @(posedge clk) begin
        if (rst) begin
            a_hold  <= 1'b0;
            oe_hold <= 1'b0;
            keep    <= 1'b0;
        end else begin
            if (cfg.hold_n) begin
                a_hold  <= a;
                oe_hold <= oe;
            end
            keep <= level;  // keeper follows every edge
        end
    end

    assign a_eff  = cfg.hold_n ? a  : a_hold;
    assign oe_eff = cfg.hold_n ? oe : oe_hold;
    assign drive  = cfg.enable & oe_eff;  // enable low forces hi-z

    // priority: core drive, external, pull, keeper
    always_comb begin
        if (drive) begin
            level = a_eff;
        end else if (ext.en) begin
            level = ext.val;
        end else if (pe) begin
            level = ps;
        end else begin
            level = keep;
        end
    end

    assign pad.level = level;
    assign pad.clash = drive & ext.en & (ext.val != a_eff);  // both sides fight
    assign z         = ie & level;  // input buffer off reads zero

endmodule

`default_nettype wire

/* logic/gpio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  gpio_pkg::apb_req_t                       apb_req,
    output gpio_pkg::apb_rsp_t                       apb_rsp,
    input  gpio_pkg::pad_ext_t [gpio_pkg::NPINS-1:0] pad_ext,  // board drivers
    output gpio_pkg::pad_obs_t [gpio_pkg::NPINS-1:0] pad,      // resolved pads
    output logic                                     irq
);
    import gpio_pkg::*;

    logic [NPINS-1:0]            dout;
    logic [NPINS-1:0]            oe;
    logic [NPINS-1:0]            ie;
    logic [NPINS-1:0]            pe;
    logic [NPINS-1:0]            ps;
    pad_cfg_t [NPINS-1:0]        cfg;
    logic [NPINS-1:0]            z;     // raw pad levels to sync
    logic [NPINS-1:0]            din;
    logic [NPINS-1:0]            rise;

    gpio_apb_regs regs_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .din     (din),
        .rise    (rise),
        .dout    (dout),
        .oe      (oe),
        .ie      (ie),
        .pe      (pe),
        .ps      (ps),
        .cfg     (cfg),
        .irq     (irq)
    );

    gpio_in_sync sync_i (
        .clk  (clk),
        .rst  (rst),
        .z    (z),
        .din  (din),
        .rise (rise)
    );

    // one cell per pin
    for (genvar i = 0; i < NPINS; i++) begin : g_pad
        la_iobidir pad_i (
            .clk (clk),
            .rst (rst),
            .a   (dout[i]),
            .z   (z[i]),
            .ie  (ie[i]),
            .oe  (oe[i]),
            .pe  (pe[i]),
            .ps  (ps[i]),
            .cfg (cfg[i]),
            .ext (pad_ext[i]),
            .pad (pad[i])
        );
    end

endmodule

`default_nettype wire

/* tests/gpio_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_checker (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     done,     // stimulus finished
    input  gpio_pkg::apb_req_t                       apb_req,
    input  gpio_pkg::apb_rsp_t                       apb_rsp,
    input  gpio_pkg::pad_ext_t [gpio_pkg::NPINS-1:0] pad_ext,
    input  gpio_pkg::pad_obs_t [gpio_pkg::NPINS-1:0] pad,
    input  logic                                     irq,
    output int                                       err_count
);
    import gpio_pkg::*;

    logic [NPINS-1:0] m_dout;
    logic [NPINS-1:0] m_oe;
    logic [NPINS-1:0] m_ie;
    logic [NPINS-1:0] m_pe;
    logic [NPINS-1:0] m_ps;
    logic [NPINS-1:0] m_mask;
    logic [NPINS-1:0] m_stat;     // sticky edge status
    pad_cfg_t         m_cfg [NPINS];
    logic [NPINS-1:0] a_hold;     // frozen drive value per pin
    logic [NPINS-1:0] oe_hold;
    logic [NPINS-1:0] keep;       // keeper level per pin
    logic [NPINS-1:0] s1;         // z one edge ago
    logic [NPINS-1:0] s2;         // z two edges ago as REG_DIN shows it
    logic [NPINS-1:0] s3;         // z three edges ago
    logic             m_irq;
    logic             valid = 1'b0;  // model holds reset state
    int               checks = 0;
    int               apb_errs = 0;
    int               pad_errs = 0;
    int               irq_errs = 0;

    assign err_count = apb_errs + pad_errs + irq_errs;

    function automatic logic addr_err(input logic [APB_AW-1:0] addr, input logic wr);
        logic mapped;
        mapped = (addr[1:0] == 2'b00) &&
                 ((addr <= REG_IRQ_MASK) || (addr >= REG_CFG0 && addr < REG_CFG_END));
        return !mapped || (wr && addr == REG_DIN);  // din is read only
    endfunction

    function automatic logic [PIN_W-1:0] cfg_index(input logic [APB_AW-1:0] addr);
        logic [APB_AW-1:0] off;
        off = addr - REG_CFG0;
        return off[PIN_W+1:2];  // one word per pin
    endfunction

    function automatic logic [APB_DW-1:0] read_value(input logic [APB_AW-1:0] addr);
        logic [APB_DW-1:0] v;
        v = '0;
        case (addr)
            REG_DOUT:     v[NPINS-1:0] = m_dout;
            REG_OE:       v[NPINS-1:0] = m_oe;
            REG_IE:       v[NPINS-1:0] = m_ie;
            REG_PE:       v[NPINS-1:0] = m_pe;
            REG_PS:       v[NPINS-1:0] = m_ps;
            REG_DIN:      v[NPINS-1:0] = s2;
            REG_IRQ_STAT: v[NPINS-1:0] = m_stat;
            REG_IRQ_MASK: v[NPINS-1:0] = m_mask;
            default:      v[CFG_W-1:0] = m_cfg[cfg_index(addr)];  // only mapped reads get here
        endcase
        return v;
    endfunction

    // drive, then external, then pull, then keeper
    function automatic pad_obs_t resolve(input int i);
        logic     a_e;
        logic     oe_e;
        logic     drv;
        pad_obs_t o;
        a_e     = m_cfg[i].hold_n ? m_dout[i] : a_hold[i];
        oe_e    = m_cfg[i].hold_n ? m_oe[i] : oe_hold[i];
        drv     = m_cfg[i].enable && oe_e;
        o.clash = drv && pad_ext[i].en && (pad_ext[i].val != a_e);
        if (drv)
            o.level = a_e;
        else if (pad_ext[i].en)
            o.level = pad_ext[i].val;
        else if (m_pe[i])
            o.level = m_ps[i];
        else
            o.level = keep[i];
        return o;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR t=%0t %s exp=0x%0h got=0x%0h", $time, name, exp, act);
    endtask

    // compare on the falling edge and step the model to the next rising edge
    always @(negedge clk) begin
        pad_obs_t          exp_pad [NPINS];
        logic [NPINS-1:0]  lvl;
        logic [NPINS-1:0]  rise;
        logic [NPINS-1:0]  clr;
        logic [NPINS-1:0]  wd;
        logic              acc;
        logic              err;
        for (int i = 0; i < NPINS; i++) begin
            exp_pad[i] = resolve(i);
            lvl[i]     = exp_pad[i].level;
        end
        acc = apb_req.psel && apb_req.penable;
        err = addr_err(apb_req.paddr, apb_req.pwrite);
        wd  = apb_req.pwdata[NPINS-1:0];
        if (valid && !done) begin
            checks++;
            for (int i = 0; i < NPINS; i++) begin
                if (pad[i] !== exp_pad[i]) begin
                    pad_errs++;
                    report_mismatch($sformatf("pad[%0d]", i), 32'(exp_pad[i]), 32'(pad[i]));
                end
            end
            if (irq !== m_irq) begin
                irq_errs++;
                report_mismatch("irq", 32'(m_irq), 32'(irq));
            end
            if (acc && apb_rsp.pready !== 1'b1) begin
                apb_errs++;  // no wait states in this block
                report_mismatch("pready", 32'(1'b1), 32'(apb_rsp.pready));
            end
            if (acc && apb_rsp.pslverr !== err) begin
                apb_errs++;
                report_mismatch("pslverr", 32'(err), 32'(apb_rsp.pslverr));
            end
            if (acc && !apb_req.pwrite && !err &&
                apb_rsp.prdata !== read_value(apb_req.paddr)) begin
                apb_errs++;
                report_mismatch($sformatf("prdata@%02h", apb_req.paddr),
                                read_value(apb_req.paddr), apb_rsp.prdata);
            end
        end
        if (rst) begin
            m_dout  = '0;
            m_oe    = '0;
            m_ie    = '1;  // inputs on out of reset
            m_pe    = '0;
            m_ps    = '0;
            m_mask  = '0;
            m_stat  = '0;
            m_irq   = 1'b0;
            a_hold  = '0;
            oe_hold = '0;
            keep    = '0;
            s1      = '0;
            s2      = '0;
            s3      = '0;
            for (int i = 0; i < NPINS; i++) begin
                m_cfg[i] = CFG_RESET;
            end
            valid = 1'b1;
        end else if (valid) begin
            rise  = s2 & ~s3;
            m_irq = |(m_stat & m_mask);  // old status and mask
            clr   = '0;
            for (int i = 0; i < NPINS; i++) begin
                if (m_cfg[i].hold_n) begin
                    a_hold[i]  = m_dout[i];
                    oe_hold[i] = m_oe[i];
                end
            end
            s3   = s2;
            s2   = s1;
            s1   = m_ie & lvl;  // input buffer gates the level
            keep = lvl;
            if (acc && apb_req.pwrite && !err) begin
                case (apb_req.paddr)
                    REG_DOUT:     m_dout = wd;
                    REG_OE:       m_oe   = wd;
                    REG_IE:       m_ie   = wd;
                    REG_PE:       m_pe   = wd;
                    REG_PS:       m_ps   = wd;
                    REG_IRQ_STAT: clr    = wd;
                    REG_IRQ_MASK: m_mask = wd;
                    default:      m_cfg[cfg_index(apb_req.paddr)] = apb_req.pwdata[CFG_W-1:0];
                endcase
            end
            m_stat = (m_stat & ~clr) | rise;  // a new edge beats the clear
        end
    end

    always @(posedge done) begin
        $display("checker: %0d cycles checked, errors apb=%0d pad=%0d irq=%0d total=%0d",
                 checks, apb_errs, pad_errs, irq_errs, err_count);
    end

endmodule

`default_nettype wire

/* tests/tb_gpio.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gpio;
    import gpio_pkg::*;

    localparam int CLK_NS       = 4;
    localparam int RST_CYC      = 8;
    localparam int NTRANS       = 400;
    localparam int TRANS_CYC    = 12;  // worst case per loop pass
    localparam int WATCHDOG_CYC = (3 * NTRANS * TRANS_CYC) / 2 + RST_CYC;

    logic                 clk;
    logic                 rst;
    logic                 done;      // tells the checker to close
    apb_req_t             apb_req;
    apb_rsp_t             apb_rsp;
    pad_ext_t [NPINS-1:0] pad_ext;   // board side drivers
    pad_obs_t [NPINS-1:0] pad;
    logic                 irq;
    int                   err_count;

    gpio_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .pad_ext (pad_ext),
        .pad     (pad),
        .irq     (irq)
    );

    gpio_checker chk_i (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .pad_ext   (pad_ext),
        .pad       (pad),
        .irq       (irq),
        .err_count (err_count)
    );

    always #(CLK_NS / 2) clk = ~clk;

    // mostly mapped word offsets, now and then any byte
    function automatic logic [APB_AW-1:0] pick_addr();
        logic [31:0] r;
        r = $urandom;
        if (r[3:0] < 4'd13)
            return {2'b00, r[7:4], 2'b00};  // 0x00 .. 0x3C
        return r[15:8];
    endfunction

    // one apb transfer, setup then access
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= wr;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        do begin
            @(posedge clk);
        end while (!apb_rsp.pready);  // completes on this edge
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    // new random board drive, held so the synchronizer settles
    task automatic change_ext();
        logic [31:0] r;
        r = $urandom;
        @(posedge clk);
        pad_ext <= r[2*NPINS-1:0];  // en and val per pin
        repeat (4) @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        void'($urandom(47));
        clk     = 1'b0;
        rst     = 1'b1;
        done    = 1'b0;
        apb_req = '0;
        pad_ext = '0;
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < NTRANS; n++) begin
            r = $urandom;
            if (r[1:0] == 2'b00)
                change_ext();
            apb_xfer(r[2], pick_addr(), $urandom);
            repeat (int'(r[4:3])) @(posedge clk);  // 0 to 3 idle cycles
        end
        repeat (6) @(posedge clk);  // drain sync and irq stages
        done <= 1'b1;
        repeat (2) @(posedge clk);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * CLK_NS);
        $display("timeout: stimulus did not complete within %0d cycles", WATCHDOG_CYC);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
logic/gpio_pkg.sv
logic/gpio_apb_regs.sv
logic/gpio_in_sync.sv
logic/la_iobidir.sv
logic/gpio_top.sv
tests/gpio_checker.sv
tests/tb_gpio.sv

/* run.sh */
#!/bin/sh
# build and run the gpio testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 -f flist.f --top-module tb_gpio \
    --Mdir "$BUILD_DIR" -o sim_gpio
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_gpio" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1
